// ==== Bender.yml ====
package:
  name: stopwatch

export_include_dirs:
  - .

sources:
  - time_pkg.sv
  - display_pkg.sv
  - sw_control.sv
  - tick_prescaler.sv
  - bcd_time_counter.sv
  - display_scan.sv
  - seg7_decoder.sv
  - stopwatch_top.sv
  - target: test
    files:
      - stopwatch_asserts.sv
      - stopwatch_tb.sv

// ==== bcd_time_counter.sv ====
`timescale 1ns/1ns
`include "stopwatch_params.svh"

module bcd_time_counter (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 tick,
  input  logic                 count_down,
  input  logic                 clear_time,
  output time_pkg::time_word_t time_now
);

  import time_pkg::*;

  time_word_t time_next;

  // Steps one digit, returns {carry or borrow, new digit}
  function automatic logic [4:0] step_digit(
    input bcd_digit_t d,
    input bcd_digit_t max_val,
    input logic       down,
    input logic       cin
  );
    logic [4:0] res;
    res = {1'b0, d};
    if (cin) begin
      if (down) begin
        if (d == '0) begin
          res = {1'b1, max_val};
        end else begin
          res = {1'b0, d - 1'b1};
        end
      end else begin
        if (d == max_val) begin
          res = {1'b1, 4'd0};
        end else begin
          res = {1'b0, d + 1'b1};
        end
      end
    end
    return res;
  endfunction

  //////////////////////////////
  // Carry and borrow chain
  //////////////////////////////

  always_comb begin
    logic       c_tenth;
    logic       c_ones;
    logic       c_tens;
    logic [4:0] min_step;
    {c_tenth, time_next.digits.tenth} =
      step_digit(time_now.digits.tenth, bcd_digit_t'(`TENTH_MAX), count_down, 1'b1);
    {c_ones, time_next.digits.sec_ones} =
      step_digit(time_now.digits.sec_ones, bcd_digit_t'(`SEC_ONES_MAX), count_down, c_tenth);
    {c_tens, time_next.digits.sec_tens} =
      step_digit(time_now.digits.sec_tens, bcd_digit_t'(`SEC_TENS_MAX), count_down, c_ones);
    // Carry out of minutes is the 9:59.9 wrap and goes nowhere
    min_step =
      step_digit(time_now.digits.min, bcd_digit_t'(`MIN_MAX), count_down, c_tens);
    time_next.digits.min = min_step[3:0];
  end

  //////////////////////////////
  // Time register
  //////////////////////////////

  // Clear wins over a tick on the same edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      time_now.raw <= '0;
    end else if (clear_time) begin
      time_now.raw <= '0;
    end else if (tick) begin
      time_now <= time_next;
    end
  end

endmodule

// ==== display_pkg.sv ====
package display_pkg;

  // Segments a..g in bits 0..6, lit when 0
  typedef logic [6:0] seg_t;

  // One bit per digit, active when 0
  typedef logic [3:0] anode_t;

  // All segments dark
  localparam seg_t SEG_BLANK = 7'b111_1111;

endpackage

// ==== display_scan.sv ====
`timescale 1ns/1ns
`include "stopwatch_params.svh"

module display_scan (
  input  logic                 clk,
  input  logic                 arst_n,
  input  time_pkg::time_word_t time_now,
  output display_pkg::anode_t  anode,
  output time_pkg::bcd_digit_t scan_digit
);

  import time_pkg::*;
  import display_pkg::*;

  localparam digit_sel_t SEL_LAST = digit_sel_t'(`DIGIT_COUNT - 1);

  digit_sel_t sel;

  // Free running, enable has no say here
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sel <= '0;
    end else if (sel == SEL_LAST) begin
      sel <= '0;
    end else begin
      sel <= sel + 1'b1;
    end
  end

  // Index 0 drives the leftmost anode, bit 3
  assign anode = ~(anode_t'(4'b1000) >> sel);

  always_comb begin
    case (sel)
      2'd0:    scan_digit = time_now.digits.min;
      2'd1:    scan_digit = time_now.digits.sec_tens;
      2'd2:    scan_digit = time_now.digits.sec_ones;
      default: scan_digit = time_now.digits.tenth;
    endcase
  end

endmodule

// ==== filelist.f ====
+incdir+.
time_pkg.sv
display_pkg.sv
sw_control.sv
tick_prescaler.sv
bcd_time_counter.sv
display_scan.sv
seg7_decoder.sv
stopwatch_top.sv
stopwatch_asserts.sv
stopwatch_tb.sv

// ==== seg7_decoder.sv ====
`timescale 1ns/1ns

module seg7_decoder (
  input  time_pkg::bcd_digit_t digit,
  output display_pkg::seg_t    segment
);

  import display_pkg::*;

  //////////////////////////////
  // Pattern table, g..a
  //////////////////////////////

  always_comb begin
    case (digit)
      4'd0:    segment = 7'b100_0000;
      4'd1:    segment = 7'b111_1001;
      4'd2:    segment = 7'b010_0100;
      4'd3:    segment = 7'b011_0000;
      4'd4:    segment = 7'b001_1001;
      4'd5:    segment = 7'b001_0010;
      4'd6:    segment = 7'b000_0010;
      4'd7:    segment = 7'b111_1000;
      4'd8:    segment = 7'b000_0000;
      4'd9:    segment = 7'b001_0000;
      // Codes above 9 stay dark
      default: segment = SEG_BLANK;
    endcase
  end

endmodule

// ==== stopwatch_asserts.sv ====
`timescale 1ns/1ns

module stopwatch_asserts (
  input logic                 clk,
  input logic                 arst_n,
  input logic                 clear_time,
  input time_pkg::time_word_t time_now,
  input time_pkg::bcd_digit_t scan_digit,
  input display_pkg::anode_t  anode
);

  // Failed assertions so far
  int fail_count = 0;

  // One digit lit at a time
  one_anode: assert property (@(posedge clk) disable iff (!arst_n) $onehot(~anode))
    else begin
      $error("anode %b does not have exactly one active bit", anode);
      fail_count++;
    end

  digit_range: assert property (@(posedge clk) disable iff (!arst_n) scan_digit <= 4'd9)
    else begin
      $error("scan digit %0d is not a BCD value", scan_digit);
      fail_count++;
    end

  // Clear lands on the next edge
  clear_zero: assert property (@(posedge clk) disable iff (!arst_n)
    clear_time |=> time_now.raw == '0)
    else begin
      $error("time %h not zero after clear", time_now.raw);
      fail_count++;
    end

endmodule

bind stopwatch_top stopwatch_asserts u_asserts (
  .clk        (clk),
  .arst_n     (arst_n),
  .clear_time (clear_time),
  .time_now   (time_now),
  .scan_digit (scan_digit),
  .anode      (anode)
);

// ==== stopwatch_params.svh ====
`ifndef STOPWATCH_PARAMS_SVH
`define STOPWATCH_PARAMS_SVH

// Enabled clock cycles per tenth step
`define TICK_DIV 4

// Digits on the display
`define DIGIT_COUNT 4

// Highest value of each time digit
`define TENTH_MAX    9
`define SEC_ONES_MAX 9
`define SEC_TENS_MAX 5
`define MIN_MAX      9

`endif

// ==== stopwatch_tb.sv ====
`timescale 1ns/1ns
`include "stopwatch_params.svh"

module stopwatch_tb;

  import time_pkg::*;
  import display_pkg::*;

  localparam int TICK_DIV    = `TICK_DIV;
  localparam int FULL_TENTHS = 6000;

  logic   clk;
  logic   arst_n;
  logic   count_up;
  logic   enable;
  logic   clr;
  anode_t anode;
  seg_t   segment;

  integer seed;
  int     checks;
  int     errors;
  int     model_tenths;

  stopwatch_top uut (
    .clk      (clk),
    .arst_n   (arst_n),
    .count_up (count_up),
    .enable   (enable),
    .clr      (clr),
    .anode    (anode),
    .segment  (segment)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////
  // Expected values
  //////////////////////////////

  // Tenths count to M:SS.T, wrapping at ten minutes
  function automatic time_word_t to_time(int tenths);
    time_word_t t;
    int         v;
    v = ((tenths % FULL_TENTHS) + FULL_TENTHS) % FULL_TENTHS;
    t.digits.min      = bcd_digit_t'(v / 600);
    t.digits.sec_tens = bcd_digit_t'((v / 100) % 6);
    t.digits.sec_ones = bcd_digit_t'((v / 10) % 10);
    t.digits.tenth    = bcd_digit_t'(v % 10);
    return t;
  endfunction

  // Active-low patterns with segment a in bit 0
  function automatic int seg_to_digit(seg_t s);
    case (s)
      7'b100_0000: return 0;
      7'b111_1001: return 1;
      7'b010_0100: return 2;
      7'b011_0000: return 3;
      7'b001_1001: return 4;
      7'b001_0010: return 5;
      7'b000_0010: return 6;
      7'b111_1000: return 7;
      7'b000_0000: return 8;
      7'b001_0000: return 9;
      default:     return -1;
    endcase
  endfunction

  function automatic int anode_to_index(anode_t a);
    case (a)
      4'b0111: return 0;
      4'b1011: return 1;
      4'b1101: return 2;
      4'b1110: return 3;
      default: return -1;
    endcase
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic check_time(time_word_t got, time_word_t exp, string what);
    checks++;
    if (got.raw !== exp.raw) begin
      errors++;
      $display("Fail at %0t ns: %s, read %0d:%0d%0d.%0d, expected %0d:%0d%0d.%0d", $time, what,
               got.digits.min, got.digits.sec_tens, got.digits.sec_ones, got.digits.tenth,
               exp.digits.min, exp.digits.sec_tens, exp.digits.sec_ones, exp.digits.tenth);
    end
  endtask

  task automatic check_anode(anode_t got, anode_t exp, string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail at %0t ns: %s, anode %b, expected %b", $time, what, got, exp);
    end
  endtask

  //////////////////////////////
  // Drivers and display reader
  //////////////////////////////

  task automatic wait_cycles(int n);
    repeat (n) @(posedge clk);
  endtask

  // Clear reaches the time register two edges after clr is driven
  task automatic pulse_clear();
    @(posedge clk) clr <= 1'b1;
    @(posedge clk) clr <= 1'b0;
    @(posedge clk);
    model_tenths = 0;
  endtask

  task automatic set_direction(logic up);
    @(posedge clk) count_up <= up;
    wait_cycles(3);
  endtask

  // Exactly n edges see enable high
  task automatic run_enabled(int n);
    if (n > 0) begin
      @(posedge clk) enable <= 1'b1;
      wait_cycles(n);
      enable <= 1'b0;
    end
  endtask

  task automatic read_display(output time_word_t t);
    int         k;
    int         idx;
    int         d;
    logic [3:0] seen;
    logic       found;
    t.raw = '0;
    seen  = '0;
    found = 1'b0;
    for (k = 0; k < 8 && !found; k++) begin
      @(negedge clk);
      found = (anode_to_index(anode) >= 0);
    end
    if (!found) begin
      errors++;
      $display("Timeout at %0t ns: no single active anode on the display", $time);
      return;
    end
    for (k = 0; k < 4; k++) begin
      if (k > 0) begin
        @(negedge clk);
      end
      idx = anode_to_index(anode);
      d   = seg_to_digit(segment);
      if (idx < 0 || d < 0) begin
        errors++;
        $display("Display unreadable at %0t ns: anode %b segment %b", $time, anode, segment);
      end else begin
        seen[idx] = 1'b1;
        case (idx)
          0:       t.digits.min      = bcd_digit_t'(d);
          1:       t.digits.sec_tens = bcd_digit_t'(d);
          2:       t.digits.sec_ones = bcd_digit_t'(d);
          default: t.digits.tenth    = bcd_digit_t'(d);
        endcase
      end
    end
    if (seen != 4'b1111) begin
      errors++;
      $display("Display scan skipped a digit at %0t ns, seen %b", $time, seen);
    end
  endtask

  task automatic expect_time(int tenths, string what);
    time_word_t t;
    read_display(t);
    check_time(t, to_time(tenths), what);
  endtask

  task automatic finish_test(string name, int errors_before);
    $display("Test %s finished, %0d errors", name, errors - errors_before);
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset();
    int k;
    int e0;
    e0 = errors;
    k  = 0;
    do begin
      @(negedge clk);
      k++;
    end while (anode !== 4'b0111 && k < 8);
    if (anode !== 4'b0111) begin
      errors++;
      $display("Timeout at %0t ns: scan never reached the minutes digit", $time);
    end else begin
      @(negedge clk) check_anode(anode, 4'b1011, "scan step 1");
      @(negedge clk) check_anode(anode, 4'b1101, "scan step 2");
      @(negedge clk) check_anode(anode, 4'b1110, "scan step 3");
    end
    expect_time(0, "after reset");
    finish_test("reset", e0);
  endtask

  task automatic test_up_count();
    int e0;
    int cycles;
    e0     = errors;
    cycles = 1 + ($unsigned($random(seed)) % 2400);
    pulse_clear();
    run_enabled(cycles);
    model_tenths = cycles / TICK_DIV;
    expect_time(model_tenths, "up count");
    finish_test("up_count", e0);
  endtask

  task automatic test_carry_wrap();
    int e0;
    e0 = errors;
    pulse_clear();
    run_enabled(599 * TICK_DIV);
    expect_time(599, "reach 0:59.9");
    run_enabled(TICK_DIV);
    expect_time(600, "carry to 1:00.0");
    run_enabled(5399 * TICK_DIV);
    expect_time(5999, "reach 9:59.9");
    run_enabled(TICK_DIV);
    expect_time(0, "wrap to 0:00.0");
    finish_test("carry_wrap", e0);
  endtask

  task automatic test_down_count();
    int e0;
    int start;
    int steps;
    e0    = errors;
    start = 5 + ($unsigned($random(seed)) % 40);
    steps = start + 1 + ($unsigned($random(seed)) % 50);
    pulse_clear();
    run_enabled(start * TICK_DIV);
    expect_time(start, "down start value");
    set_direction(1'b0);
    run_enabled(steps * TICK_DIV);
    model_tenths = ((start - steps) % FULL_TENTHS + FULL_TENTHS) % FULL_TENTHS;
    expect_time(model_tenths, "down count through zero");
    finish_test("down_count", e0);
  endtask

  task automatic test_freeze_clear();
    int e0;
    e0 = errors;
    set_direction(1'b1);
    // Partial period leaves the prescaler mid-count
    run_enabled(TICK_DIV - 2);
    expect_time(model_tenths, "before freeze");
    wait_cycles(60);
    expect_time(model_tenths, "after freeze");
    pulse_clear();
    expect_time(0, "after clear");
    run_enabled(TICK_DIV - 1);
    expect_time(0, "one cycle short of a period");
    run_enabled(1);
    expect_time(1, "first step after clear");
    finish_test("freeze_clear", e0);
  endtask

  initial begin
    seed         = 32'had6eae7b;
    checks       = 0;
    errors       = 0;
    model_tenths = 0;
    arst_n       = 1'b0;
    count_up     = 1'b1;
    enable       = 1'b0;
    clr          = 1'b0;
    repeat (2) @(posedge clk);
    arst_n <= 1'b1;
    test_reset();
    test_up_count();
    test_carry_wrap();
    test_down_count();
    test_freeze_clear();
    errors += uut.u_asserts.fail_count;
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// ==== stopwatch_top.sv ====
`timescale 1ns/1ns

module stopwatch_top (
  input  logic                clk,
  input  logic                arst_n,
  input  logic                count_up,
  input  logic                enable,
  input  logic                clr,
  output display_pkg::anode_t anode,
  output display_pkg::seg_t   segment
);

  import time_pkg::*;

  logic       count_down;
  logic       clear_time;
  logic       tick;
  time_word_t time_now;
  bcd_digit_t scan_digit;

  //////////////////////////////
  // Control
  //////////////////////////////

  sw_control u_sw_control (
    .clk        (clk),
    .arst_n     (arst_n),
    .count_up   (count_up),
    .clr        (clr),
    .count_down (count_down),
    .clear_time (clear_time)
  );

  tick_prescaler u_tick_prescaler (
    .clk        (clk),
    .arst_n     (arst_n),
    .enable     (enable),
    .clear_time (clear_time),
    .tick       (tick)
  );

  //////////////////////////////
  // Time and display
  //////////////////////////////

  bcd_time_counter u_bcd_time_counter (
    .clk        (clk),
    .arst_n     (arst_n),
    .tick       (tick),
    .count_down (count_down),
    .clear_time (clear_time),
    .time_now   (time_now)
  );

  display_scan u_display_scan (
    .clk        (clk),
    .arst_n     (arst_n),
    .time_now   (time_now),
    .anode      (anode),
    .scan_digit (scan_digit)
  );

  seg7_decoder u_seg7_decoder (
    .digit   (scan_digit),
    .segment (segment)
  );

endmodule

// ==== sw_control.sv ====
`timescale 1ns/1ns

module sw_control (
  input  logic clk,
  input  logic arst_n,
  input  logic count_up,
  input  logic clr,
  output logic count_down,
  output logic clear_time
);

  logic up_meta;

  //////////////////////////////
  // Direction
  //////////////////////////////

  // Two stages from the switch, the second one holds the direction
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      up_meta    <= 1'b1;
      count_down <= 1'b0;
    end else begin
      up_meta    <= count_up;
      count_down <= ~up_meta;
    end
  end

  //////////////////////////////
  // Clear
  //////////////////////////////

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      clear_time <= 1'b0;
    end else begin
      clear_time <= clr;
    end
  end

endmodule

// ==== tick_prescaler.sv ====
`timescale 1ns/1ns
`include "stopwatch_params.svh"

module tick_prescaler (
  input  logic clk,
  input  logic arst_n,
  input  logic enable,
  input  logic clear_time,
  output logic tick
);

  localparam int CNT_W = (`TICK_DIV > 1) ? $clog2(`TICK_DIV) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`TICK_DIV - 1);

  logic [CNT_W-1:0] cnt;
  logic             run;

  // Counting only while running and not being cleared
  assign run  = enable & ~clear_time;
  assign tick = run & (cnt == CNT_LAST);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cnt <= '0;
    end else if (clear_time || tick) begin
      cnt <= '0;
    end else if (run) begin
      cnt <= cnt + 1'b1;
    end
  end

endmodule

// ==== time_pkg.sv ====
package time_pkg;

  // One BCD digit
  typedef logic [3:0] bcd_digit_t;

  // Display position, 0 is minutes and 3 is tenths
  typedef logic [1:0] digit_sel_t;

  // M:SS.T, most significant digit first
  typedef struct packed {
    bcd_digit_t min;
    bcd_digit_t sec_tens;
    bcd_digit_t sec_ones;
    bcd_digit_t tenth;
  } time_digits_t;

  // Same 16 bits seen flat or per digit
  typedef union packed {
    logic [15:0]  raw;
    time_digits_t digits;
  } time_word_t;

endpackage
